// ==== compile.f ====
+incdir+logic
logic/sldu_insn_pkg.sv
logic/sldu_data_pkg.sv
logic/sldu_fifo.sv
logic/sldu_issue.sv
logic/sldu_writeback.sv
logic/sldu_top.sv
tb/tb_sldu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_sldu -Mdir obj_dir
	./obj_dir/Vtb_sldu | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_sldu.sv ====
// Testbench for the vector slide unit
// Directed slides checked against a byte-level register-file model
`timescale 1ns/1ps
`include "sldu_cfg.svh"

module tb_sldu;

  localparam int NrBytes  = `SLDU_NR_BYTES;
  localparam int RegWords = `SLDU_REG_WORDS;
  localparam int RegBytes = NrBytes * RegWords;
  localparam int NrWords  = RegWords * `SLDU_NR_REGS;
  // Six slides of a few dozen cycles each, wide margin for random grants
  localparam int CycleLimit = 2000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_valid_i;
  sldu_insn_pkg::slide_req_t req_i;
  logic                      req_ready_o;
  logic                      operand_valid_i;
  sldu_data_pkg::word_t      operand_i;
  logic                      operand_ready_o;
  logic                      wr_req_o;
  sldu_data_pkg::vaddr_t     wr_addr_o;
  sldu_data_pkg::word_t      wr_data_o;
  sldu_data_pkg::strb_t      wr_be_o;
  logic                      wr_gnt_i;
  logic                      done_valid_o;
  sldu_insn_pkg::insn_id_t   done_id_o;

  // Register-file model and the image it should reach
  logic [7:0]           vrf [NrWords*NrBytes];
  logic [7:0]           exp_vrf [NrWords*NrBytes];
  // Per word address, expected strobe, target flag and granted writes
  sldu_data_pkg::strb_t exp_be [NrWords];
  bit                   exp_wr [NrWords];
  int                   wr_cnt [NrWords];

  // Source words still to hand over, ids still to report
  sldu_data_pkg::word_t    op_q [$];
  sldu_insn_pkg::insn_id_t done_q [$];

  logic        op_taken;
  logic        rand_gnt;
  integer      seed;
  logic [31:0] rnd;
  int          cycles = 0;

  // Write seen waiting without grant
  logic                  held_req;
  sldu_data_pkg::vaddr_t held_addr;
  sldu_data_pkg::word_t  held_data;
  sldu_data_pkg::strb_t  held_be;

  sldu_top sldu_top_i (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      abort_run("Timeout, the DUT did not finish the tests within the cycle limit");
    end
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // Drivers and monitor
  //////////////////////////////

  // Operand stream and grant change 1 ns after the edge
  always @(posedge clk_i) begin
    #1;
    if (op_taken) void'(op_q.pop_front());
    operand_valid_i = (op_q.size() != 0);
    operand_i       = (op_q.size() != 0) ? op_q[0] : '0;
    rnd             = $random(seed);
    wr_gnt_i        = rand_gnt ? rnd[0] : 1'b1;
  end

  // Mid-cycle sampling, values hold until the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      op_taken = operand_valid_i && operand_ready_o;
      // Ungranted write must not move
      if (held_req) begin
        check_value("wr_req_o", wr_req_o, 1'b1);
        check_value("wr_addr_o", wr_addr_o, held_addr);
        check_value("wr_data_o", wr_data_o, held_data);
        check_value("wr_be_o", wr_be_o, held_be);
      end
      if (wr_req_o && wr_gnt_i) begin
        if (!exp_wr[wr_addr_o]) begin
          abort_run($sformatf("Write to word address %0d, which no slide targets",
                              wr_addr_o));
        end else begin
          check_value($sformatf("wr_be_o at address %0d", wr_addr_o), wr_be_o,
                      exp_be[wr_addr_o]);
          wr_cnt[wr_addr_o]++;
          for (int b = 0; b < NrBytes; b++) begin
            if (wr_be_o[b]) vrf[int'(wr_addr_o)*NrBytes + b] = wr_data_o[8*b +: 8];
          end
        end
      end
      held_req  = wr_req_o && !wr_gnt_i;
      held_addr = wr_addr_o;
      held_data = wr_data_o;
      held_be   = wr_be_o;
      // Done ids in request order
      if (done_valid_o) begin
        if (done_q.size() == 0) begin
          abort_run("Done pulse while no instruction was outstanding");
        end else begin
          check_value("done_id_o", done_id_o, done_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////
  // Slide helpers
  //////////////////////////////

  // Source words from the model, in order from word 0
  task automatic feed_operands(input int vs2, input int nwords);
    sldu_data_pkg::word_t w;
    for (int k = 0; k < nwords; k++) begin
      for (int b = 0; b < NrBytes; b++) begin
        w[8*b +: 8] = vrf[vs2*RegBytes + k*NrBytes + b];
      end
      op_q.push_back(w);
    end
  endtask

  task automatic start_test();
    for (int a = 0; a < NrWords*NrBytes; a++) exp_vrf[a] = vrf[a];
    for (int w = 0; w < NrWords; w++) begin
      exp_be[w] = '0;
      exp_wr[w] = 1'b0;
      wr_cnt[w] = 0;
    end
    @(posedge clk_i);
    #1;
  endtask

  // Expected image from the slide rule, then the request itself
  task automatic issue_slide(input sldu_insn_pkg::slide_op_e op, input int id,
                             input int vs2, input int vd, input int vl, input int stride);
    bit up;
    int first_w;
    int nwords;
    up      = (op == sldu_insn_pkg::SLIDE_UP);
    first_w = up ? stride / NrBytes : 0;
    for (int i = 0; i < vl; i++) begin
      if (!up || i >= stride) begin
        exp_vrf[vd*RegBytes + i] = up ? vrf[vs2*RegBytes + i - stride]
                                      : vrf[vs2*RegBytes + i + stride];
        exp_be[vd*RegWords + i/NrBytes][i%NrBytes] = 1'b1;
      end
    end
    for (int k = first_w; k <= (vl - 1) / NrBytes; k++) exp_wr[vd*RegWords + k] = 1'b1;
    // Slide-up reads bytes below vl - stride, slide-down up to vl + stride
    nwords = up ? (vl - stride + NrBytes - 1) / NrBytes
                : (vl + stride + NrBytes - 1) / NrBytes;
    feed_operands(vs2, nwords);
    done_q.push_back(sldu_insn_pkg::insn_id_t'(id));

    req_valid_i   = 1'b1;
    req_i.op      = op;
    req_i.id      = sldu_insn_pkg::insn_id_t'(id);
    req_i.vs2     = sldu_insn_pkg::vreg_t'(vs2);
    req_i.vd      = sldu_insn_pkg::vreg_t'(vd);
    req_i.vl      = sldu_insn_pkg::vlen_t'(vl);
    req_i.stride  = sldu_insn_pkg::vlen_t'(stride);
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Drain, then compare the whole register file and the write counts
  task automatic finish_test();
    while (done_q.size() != 0) @(negedge clk_i);
    check_value("operand words left", op_q.size(), 0);
    for (int w = 0; w < NrWords; w++) begin
      check_value($sformatf("write count at address %0d", w), wr_cnt[w], exp_wr[w] ? 1 : 0);
    end
    for (int a = 0; a < NrWords*NrBytes; a++) begin
      check_value($sformatf("vrf byte %0d", a), vrf[a], exp_vrf[a]);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_up_aligned();
    start_test();
    issue_slide(sldu_insn_pkg::SLIDE_UP, 0, 1, 2, 32, 8);
    finish_test();
  endtask

  task automatic test_down_unaligned();
    start_test();
    issue_slide(sldu_insn_pkg::SLIDE_DOWN, 3, 3, 4, 27, 5);
    finish_test();
  endtask

  // Strobes cover bytes 3 to 19, checked per write by the monitor
  task automatic test_up_unaligned();
    start_test();
    issue_slide(sldu_insn_pkg::SLIDE_UP, 1, 5, 6, 20, 3);
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test();
    rand_gnt = 1'b1;
    issue_slide(sldu_insn_pkg::SLIDE_DOWN, 2, 3, 7, 27, 5);
    finish_test();
    rand_gnt = 1'b0;
  endtask

  task automatic test_back_to_back();
    start_test();
    issue_slide(sldu_insn_pkg::SLIDE_DOWN, 1, 1, 5, 24, 2);
    issue_slide(sldu_insn_pkg::SLIDE_UP, 2, 3, 6, 30, 10);
    finish_test();
  endtask

  initial begin
    seed            = 32'h9f43;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    operand_valid_i = 1'b0;
    operand_i       = '0;
    wr_gnt_i        = 1'b0;
    rand_gnt        = 1'b0;
    op_taken        = 1'b0;
    held_req        = 1'b0;
    for (int a = 0; a < NrWords*NrBytes; a++) vrf[a] = 8'($random(seed));

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    check_value("req_ready_o", req_ready_o, 1'b1);
    check_value("operand_ready_o", operand_ready_o, 1'b0);
    check_value("wr_req_o", wr_req_o, 1'b0);
    check_value("done_valid_o", done_valid_o, 1'b0);

    test_up_aligned();
    test_down_unaligned();
    test_up_unaligned();
    test_backpressure();
    test_back_to_back();

    $display("No errors");
    $finish;
  end

endmodule

// ==== logic/sldu_top.sv ====
// Vector slide unit top level
// Instruction queue, slide engine, result queue and write-back in a chain
`timescale 1ns/1ps
`include "sldu_cfg.svh"

module sldu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sequencer requests
  input  logic                      req_valid_i,
  input  sldu_insn_pkg::slide_req_t req_i,
  output logic                      req_ready_o,
  // Source operand stream
  input  logic                      operand_valid_i,
  input  sldu_data_pkg::word_t      operand_i,
  output logic                      operand_ready_o,
  // Register-file write port
  output logic                      wr_req_o,
  output sldu_data_pkg::vaddr_t     wr_addr_o,
  output sldu_data_pkg::word_t      wr_data_o,
  output sldu_data_pkg::strb_t      wr_be_o,
  input  logic                      wr_gnt_i,
  // Instruction done
  output logic                      done_valid_o,
  output sldu_insn_pkg::insn_id_t   done_id_o
);

  // Queue head to engine
  logic                      insn_valid;
  sldu_insn_pkg::slide_req_t insn;
  logic                      insn_ready;

  // Engine to result queue
  logic                      res_valid;
  sldu_data_pkg::result_t    res;
  logic                      res_ready;

  // Result queue to write-back
  logic                      wb_valid;
  sldu_data_pkg::result_t    wb_res;
  logic                      wb_ready;

  //////////////////////////////
  // Instruction queue
  //////////////////////////////

  sldu_fifo #(
    .T    (sldu_insn_pkg::slide_req_t),
    .DEPTH(`SLDU_INSN_DEPTH)
  ) u_insn_q (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (req_valid_i),
    .in_data_i  (req_i),
    .in_ready_o (req_ready_o),
    .out_valid_o(insn_valid),
    .out_data_o (insn),
    .out_ready_i(insn_ready)
  );

  //////////////////////////////
  // Slide engine
  //////////////////////////////

  sldu_issue u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_valid_i   (insn_valid),
    .insn_i         (insn),
    .insn_ready_o   (insn_ready),
    .operand_valid_i(operand_valid_i),
    .operand_i      (operand_i),
    .operand_ready_o(operand_ready_o),
    .res_valid_o    (res_valid),
    .res_o          (res),
    .res_ready_i    (res_ready)
  );

  //////////////////////////////
  // Result queue and write-back
  //////////////////////////////

  sldu_fifo #(
    .T    (sldu_data_pkg::result_t),
    .DEPTH(`SLDU_RESULT_DEPTH)
  ) u_result_q (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (res_valid),
    .in_data_i  (res),
    .in_ready_o (res_ready),
    .out_valid_o(wb_valid),
    .out_data_o (wb_res),
    .out_ready_i(wb_ready)
  );

  sldu_writeback u_writeback (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_valid_i (wb_valid),
    .res_i       (wb_res),
    .res_ready_o (wb_ready),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .wr_be_o     (wr_be_o),
    .wr_gnt_i    (wr_gnt_i),
    .done_valid_o(done_valid_o),
    .done_id_o   (done_id_o)
  );

endmodule

// ==== logic/sldu_writeback.sv ====
// Register-file write port of the slide unit
// Holds one write until granted and reports each finished instruction
`timescale 1ns/1ps

module sldu_writeback (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    res_valid_i,
  input  sldu_data_pkg::result_t  res_i,
  output logic                    res_ready_o,
  output logic                    wr_req_o,
  output sldu_data_pkg::vaddr_t   wr_addr_o,
  output sldu_data_pkg::word_t    wr_data_o,
  output sldu_data_pkg::strb_t    wr_be_o,
  input  logic                    wr_gnt_i,
  output logic                    done_valid_o,
  output sldu_insn_pkg::insn_id_t done_id_o
);

  logic                    wr_req_q;
  sldu_data_pkg::result_t  wr_q;
  logic                    granted;
  logic                    done_valid_q;
  sldu_insn_pkg::insn_id_t done_id_q;

  // Slot frees up when empty or granted this cycle
  assign granted     = wr_req_q & wr_gnt_i;
  assign res_ready_o = ~wr_req_q | wr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_req_q     <= 1'b0;
      done_valid_q <= 1'b0;
    end else begin
      if (res_ready_o) wr_req_q <= res_valid_i;
      // One-cycle pulse after the last word is granted
      done_valid_q <= granted & wr_q.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_ready_o) wr_q <= res_i;
    if (granted && wr_q.last) done_id_q <= wr_q.id;
  end

  assign wr_req_o     = wr_req_q;
  assign wr_addr_o    = wr_q.addr;
  assign wr_data_o    = wr_q.wdata;
  assign wr_be_o      = wr_q.be;
  assign done_valid_o = done_valid_q;
  assign done_id_o    = done_id_q;

endmodule

// ==== logic/sldu_issue.sv ====
// Slide engine of the slide unit
// Copies operand bytes by a byte stride into byte-enabled result words
`timescale 1ns/1ps
`include "sldu_cfg.svh"

module sldu_issue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      insn_valid_i,
  input  sldu_insn_pkg::slide_req_t insn_i,
  output logic                      insn_ready_o,
  input  logic                      operand_valid_i,
  input  sldu_data_pkg::word_t      operand_i,
  output logic                      operand_ready_o,
  output logic                      res_valid_o,
  output sldu_data_pkg::result_t    res_o,
  input  logic                      res_ready_i
);

  localparam int unsigned NrBytes  = `SLDU_NR_BYTES;
  localparam int unsigned ByteIdxW = $clog2(NrBytes);
  localparam int unsigned PntW     = ByteIdxW + 1;
  localparam int unsigned RegWords = `SLDU_REG_WORDS;
  localparam int unsigned WordIdxW = $clog2(RegWords);
  localparam int unsigned VlBits   = `SLDU_VL_BITS;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  //////////////////////////////
  // Engine state
  //////////////////////////////

  state_e                     state_d, state_q;
  // Byte pointers inside the current input and output word, 0 to 8
  logic [PntW-1:0]            in_pnt_d, in_pnt_q;
  logic [PntW-1:0]            out_pnt_d, out_pnt_q;
  // Bytes still to issue and the end of the destination range
  logic [VlBits-1:0]          issue_cnt_d, issue_cnt_q;
  logic [VlBits-1:0]          output_limit_d, output_limit_q;
  // Word index inside the destination register
  logic [WordIdxW-1:0]        vrf_pnt_d, vrf_pnt_q;
  // Leading source words a slide-down drops unused
  logic [VlBits-ByteIdxW-1:0] skip_d, skip_q;

  // Word under assembly and the pushed result
  sldu_data_pkg::word_t       asm_data_d, asm_data_q;
  sldu_data_pkg::strb_t       asm_be_d, asm_be_q;
  sldu_data_pkg::result_t     res_d, res_q;
  logic                       res_valid_d, res_valid_q;

  //////////////////////////////
  // Byte datapath
  //////////////////////////////

  logic [PntW-1:0]            byte_count;
  logic [ByteIdxW-1:0]        rot_amt;
  logic [2*8*NrBytes-1:0]     op_dbl;
  sldu_data_pkg::word_t       op_rot;
  sldu_data_pkg::strb_t       out_en;
  sldu_data_pkg::vaddr_t      vrf_addr;
  logic                       in_done, out_done, finish;

  // Bytes moved this cycle, the smaller room of the two words
  assign byte_count = (in_pnt_q > out_pnt_q) ? PntW'(NrBytes) - in_pnt_q
                                             : PntW'(NrBytes) - out_pnt_q;

  // Rotate so input byte in_pnt lines up with output byte out_pnt
  assign rot_amt = ByteIdxW'(in_pnt_q - out_pnt_q);
  assign op_dbl  = {operand_i, operand_i};
  assign op_rot  = op_dbl[8*rot_amt +: 8*NrBytes];

  // Output window, clipped to this step and to vl
  always_comb begin
    for (int b = 0; b < NrBytes; b++) begin
      out_en[b] = (b >= int'(out_pnt_q)) &&
                  (b < int'(out_pnt_q) + int'(byte_count)) &&
                  (int'(vrf_pnt_q) * int'(NrBytes) + b < int'(output_limit_q));
    end
  end

  assign finish   = (issue_cnt_q <= VlBits'(byte_count));
  assign in_done  = (in_pnt_q + byte_count == PntW'(NrBytes)) || finish;
  assign out_done = (out_pnt_q + byte_count == PntW'(NrBytes)) || finish;

  // Register-file word address for the word being built
  assign vrf_addr = sldu_data_pkg::vaddr_t'(insn_i.vd) *
                    sldu_data_pkg::vaddr_t'(RegWords) +
                    sldu_data_pkg::vaddr_t'(vrf_pnt_q);

  //////////////////////////////
  // Slide FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    output_limit_d  = output_limit_q;
    vrf_pnt_d       = vrf_pnt_q;
    skip_d          = skip_q;
    asm_data_d      = asm_data_q;
    asm_be_d        = asm_be_q;
    res_d           = res_q;
    // Pending result leaves when the queue takes it
    res_valid_d     = res_valid_q & ~res_ready_i;
    insn_ready_o    = 1'b0;
    operand_ready_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (insn_valid_i) begin
          state_d        = ST_RUN;
          output_limit_d = insn_i.vl;
          if (insn_i.op == sldu_insn_pkg::SLIDE_UP) begin
            // Read from byte 0, write from the stride on
            in_pnt_d    = '0;
            out_pnt_d   = PntW'(insn_i.stride[ByteIdxW-1:0]);
            vrf_pnt_d   = WordIdxW'(insn_i.stride >> ByteIdxW);
            issue_cnt_d = insn_i.vl - insn_i.stride;
            skip_d      = '0;
          end else begin
            // Read from the stride on, write from byte 0
            in_pnt_d    = PntW'(insn_i.stride[ByteIdxW-1:0]);
            out_pnt_d   = '0;
            vrf_pnt_d   = '0;
            issue_cnt_d = insn_i.vl;
            skip_d      = insn_i.stride[VlBits-1:ByteIdxW];
          end
        end
      end

      ST_RUN: begin
        if (skip_q != '0) begin
          // Source words wholly below the stride
          operand_ready_o = 1'b1;
          if (operand_valid_i) skip_d = skip_q - 1'b1;
        end else if (operand_valid_i && (!res_valid_q || res_ready_i)) begin
          // Merge this step's bytes
          for (int b = 0; b < NrBytes; b++) begin
            if (out_en[b]) asm_data_d[8*b +: 8] = op_rot[8*b +: 8];
          end
          asm_be_d    = asm_be_q | out_en;
          in_pnt_d    = in_pnt_q + byte_count;
          out_pnt_d   = out_pnt_q + byte_count;
          issue_cnt_d = finish ? '0 : issue_cnt_q - VlBits'(byte_count);

          // Input word used up, take the next one
          if (in_done) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end

          // Output word full or instruction over
          if (out_done) begin
            out_pnt_d   = '0;
            vrf_pnt_d   = vrf_pnt_q + 1'b1;
            res_d.id    = insn_i.id;
            res_d.addr  = vrf_addr;
            res_d.wdata = asm_data_d;
            res_d.be    = asm_be_d;
            res_d.last  = finish;
            res_valid_d = 1'b1;
            asm_be_d    = '0;
          end

          // Last word issued, retire the instruction
          if (finish) begin
            state_d      = ST_IDLE;
            insn_ready_o = 1'b1;
          end
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= ST_IDLE;
      in_pnt_q       <= '0;
      out_pnt_q      <= '0;
      issue_cnt_q    <= '0;
      output_limit_q <= '0;
      vrf_pnt_q      <= '0;
      skip_q         <= '0;
      asm_be_q       <= '0;
      res_valid_q    <= 1'b0;
    end else begin
      state_q        <= state_d;
      in_pnt_q       <= in_pnt_d;
      out_pnt_q      <= out_pnt_d;
      issue_cnt_q    <= issue_cnt_d;
      output_limit_q <= output_limit_d;
      vrf_pnt_q      <= vrf_pnt_d;
      skip_q         <= skip_d;
      asm_be_q       <= asm_be_d;
      res_valid_q    <= res_valid_d;
    end
  end

  // Word payloads
  always_ff @(posedge clk_i) begin
    asm_data_q <= asm_data_d;
    res_q      <= res_d;
  end

endmodule

// ==== logic/sldu_fifo.sv ====
// Circular queue with valid/ready on both sides
// Payload type is a parameter so one block serves instructions and results
`timescale 1ns/1ps

module sldu_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output T     out_data_o,
  input  logic out_ready_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  // Storage and its bookkeeping
  T                mem_q [DEPTH];
  logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push, pop;

  // Pointer increment with wrap at DEPTH
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    nxt = (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // Full blocks the writer, empty hides the head
  assign in_ready_o  = (cnt_q != CntW'(DEPTH));
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      // Occupancy moves only when exactly one side transfers
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry write, visible at the head one cycle later
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

// ==== logic/sldu_data_pkg.sv ====
// Data-side types of the slide unit
// Words, byte strobes, register-file addresses and result payloads
`include "sldu_cfg.svh"

package sldu_data_pkg;

  // One data word and its byte enables
  typedef logic [8*`SLDU_NR_BYTES-1:0] word_t;
  typedef logic [`SLDU_NR_BYTES-1:0]   strb_t;

  // Word address into the whole register file
  // vd * words per register + word index
  typedef logic [$clog2(`SLDU_NR_REGS*`SLDU_REG_WORDS)-1:0] vaddr_t;

  // One result word on its way to the register file
  typedef struct packed {
    sldu_insn_pkg::insn_id_t id;
    vaddr_t                  addr;
    word_t                   wdata;
    strb_t                   be;
    // Final word of the instruction
    logic                    last;
  } result_t;

endpackage

// ==== logic/sldu_insn_pkg.sv ====
// Instruction-side types of the slide unit
// Opcode, instruction id and the request issued by the sequencer
`include "sldu_cfg.svh"

package sldu_insn_pkg;

  // Slide direction
  typedef enum logic {
    SLIDE_UP   = 1'b0,
    SLIDE_DOWN = 1'b1
  } slide_op_e;

  // Id returned with the done pulse
  typedef logic [1:0] insn_id_t;

  // Vector register index
  typedef logic [$clog2(`SLDU_NR_REGS)-1:0] vreg_t;

  // Byte count for vl and stride
  typedef logic [`SLDU_VL_BITS-1:0] vlen_t;

  // One slide instruction, vl and stride in bytes
  typedef struct packed {
    slide_op_e op;
    insn_id_t  id;
    vreg_t     vs2;
    vreg_t     vd;
    vlen_t     vl;
    vlen_t     stride;
  } slide_req_t;

endpackage

// ==== logic/sldu_cfg.svh ====
// Slide unit configuration
// Word size, queue depths and vector register geometry
`ifndef SLDU_CFG_SVH
`define SLDU_CFG_SVH

// Bytes per data word
`define SLDU_NR_BYTES 8

// Queue depths
`define SLDU_INSN_DEPTH 2
`define SLDU_RESULT_DEPTH 2

// Register file shape, 4 words of 8 bytes per register
`define SLDU_REG_WORDS 4
`define SLDU_NR_REGS 8

// Width of vl and stride, counted in bytes
`define SLDU_VL_BITS 6

`endif
